// ==== Makefile ====
# Verilator build for the matmul tile testbench
# Override any variable on the command line, for example: make run SEED=1234

VERILATOR ?= verilator
TOP       ?= tb_matmul_tile
SEED      ?= 23714
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		--Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)

# The simulator exits with a failing status on any fatal error
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// ==== tb.f ====
verilog/matmul_pkg.sv
verilog/operand_feeder.sv
verilog/sat_mac_pe.sv
verilog/systolic_array.sv
verilog/drain_sequencer.sv
verilog/matmul_tile.sv
verification/tb_matmul_tile.sv

// ==== verification/tb_matmul_tile.sv ====
module tb_matmul_tile;

  import matmul_pkg::*;

  parameter int SEED = 23714;

  localparam int JOB_RANDOM = 0;
  localparam int JOB_IDENTITY = 1;
  localparam int JOB_SATURATE = 2;
  localparam int NUM_JOBS = 7;
  localparam int WATCHDOG_CYCLES = NUM_JOBS * (DONE_CYCLE + 10);
  // Count holds at 0 for one start-up cycle, and the pulse is registered
  localparam int DONE_EDGE = DONE_CYCLE + 2;
  localparam int SAT_MAX = 2 ** (DWIDTH - 1) - 1;
  localparam int SAT_MIN = -(2 ** (DWIDTH - 1));
  // Driven on the data bus whenever no read is pending
  localparam logic [ROW_WIDTH-1:0] BUS_JUNK = 32'hA55A_7E81;

  logic                     clk;
  logic                     reset;
  logic                     i_start;
  logic [AWIDTH-1:0]        i_base_a;
  logic [AWIDTH-1:0]        i_base_b;
  logic [AWIDTH-1:0]        i_base_c;
  logic [ROW_WIDTH-1:0]     i_a_data;
  logic [ROW_WIDTH-1:0]     i_b_data;
  logic [AWIDTH-1:0]        o_a_addr;
  logic [AWIDTH-1:0]        o_b_addr;
  logic                     o_a_rd_en;
  logic                     o_b_rd_en;
  logic [AWIDTH-1:0]        o_c_addr;
  logic [ROW_WIDTH-1:0]     o_c_data;
  logic                     o_c_valid;
  logic                     o_done;

  logic [ROW_WIDTH-1:0]     mem_a [1 << AWIDTH];
  logic [ROW_WIDTH-1:0]     mem_b [1 << AWIDTH];
  logic [AWIDTH-1:0]        a_addr_pipe [MEM_LATENCY];
  logic [AWIDTH-1:0]        b_addr_pipe [MEM_LATENCY];
  logic [MEM_LATENCY-1:0]   a_en_pipe;
  logic [MEM_LATENCY-1:0]   b_en_pipe;
  logic signed [DWIDTH-1:0] mat_a [MAT_SIZE][MAT_SIZE];
  logic signed [DWIDTH-1:0] mat_b [MAT_SIZE][MAT_SIZE];
  logic [DWIDTH-1:0]        exp_c [MAT_SIZE][MAT_SIZE];
  logic [15:0]              lfsr_state;
  int                       beat_count;
  int                       done_count;
  int                       a_fetch_count;
  int                       b_fetch_count;

  matmul_tile #(.MEM_LAT(MEM_LATENCY)) UUT (
    .clk       (clk),
    .reset     (reset),
    .i_start   (i_start),
    .i_base_a  (i_base_a),
    .i_base_b  (i_base_b),
    .i_base_c  (i_base_c),
    .i_a_data  (i_a_data),
    .i_b_data  (i_b_data),
    .o_a_addr  (o_a_addr),
    .o_b_addr  (o_b_addr),
    .o_a_rd_en (o_a_rd_en),
    .o_b_rd_en (o_b_rd_en),
    .o_c_addr  (o_c_addr),
    .o_c_data  (o_c_data),
    .o_c_valid (o_c_valid),
    .o_done    (o_done)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("Verification failed");
      $fatal(1, "stopping at the first error");
    end
  endtask

  // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    logic        feedback;
    value = '0;
    for (int n = 0; n < count; n++) begin
      feedback = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], feedback};
      value = {value[30:0], feedback};
    end
    return value;
  endfunction

  function automatic logic [ROW_WIDTH-1:0] fill_word(input logic [AWIDTH-1:0] addr,
                                                     input logic salt);
    return salt ? {6'h15, ~addr, 6'h2A, addr} : {6'h2A, addr, 6'h15, ~addr};
  endfunction

  function automatic logic [AWIDTH-1:0] stride_addr(input logic [AWIDTH-1:0] base, input int k);
    return base + AWIDTH'(k * MAT_SIZE);
  endfunction

  // C[i][j] is the wrapping sum of products clamped to the signed element range
  function automatic logic [DWIDTH-1:0] ref_element(input int row, input int col);
    int                prod;
    int                clamped;
    logic [DWIDTH-1:0] acc;
    acc = '0;
    for (int k = 0; k < MAT_SIZE; k++) begin
      prod = int'(mat_a[row][k]) * int'(mat_b[k][col]);
      clamped = (prod > SAT_MAX) ? SAT_MAX : ((prod < SAT_MIN) ? SAT_MIN : prod);
      acc = acc + DWIDTH'(clamped);
    end
    return acc;
  endfunction

  function automatic logic [ROW_WIDTH-1:0] expected_column(input int col);
    logic [ROW_WIDTH-1:0] word;
    for (int i = 0; i < MAT_SIZE; i++) begin
      word[i*DWIDTH +: DWIDTH] = exp_c[i][col];
    end
    return word;
  endfunction

  ////////////////////////////////////////////////////////////
  // Memory model, data returns MEM_LATENCY cycles after the address
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    i_a_data <= a_en_pipe[MEM_LATENCY-1] ? mem_a[a_addr_pipe[MEM_LATENCY-1]] : BUS_JUNK;
    i_b_data <= b_en_pipe[MEM_LATENCY-1] ? mem_b[b_addr_pipe[MEM_LATENCY-1]] : BUS_JUNK;
    a_addr_pipe[0] <= o_a_addr;
    b_addr_pipe[0] <= o_b_addr;
    a_en_pipe[0] <= o_a_rd_en;
    b_en_pipe[0] <= o_b_rd_en;
    for (int s = 1; s < MEM_LATENCY; s++) begin
      a_addr_pipe[s] <= a_addr_pipe[s-1];
      b_addr_pipe[s] <= b_addr_pipe[s-1];
      a_en_pipe[s] <= a_en_pipe[s-1];
      b_en_pipe[s] <= b_en_pipe[s-1];
    end
  end

  // Compare results, fetch addresses and done against the expected job
  always @(negedge clk) begin
    if (!reset) begin
      if (o_c_valid) begin
        check_value("o_c_addr", 32'(o_c_addr), 32'(stride_addr(i_base_c, beat_count)));
        check_value("o_c_data", o_c_data, expected_column(beat_count));
        beat_count++;
      end
      if (o_a_rd_en) begin
        check_value("o_a_addr", 32'(o_a_addr), 32'(stride_addr(i_base_a, a_fetch_count)));
        a_fetch_count++;
      end
      if (o_b_rd_en) begin
        check_value("o_b_addr", 32'(o_b_addr), 32'(stride_addr(i_base_b, b_fetch_count)));
        b_fetch_count++;
      end
      if (o_done) begin
        check_value("result beats before o_done", 32'(beat_count), 32'(MAT_SIZE));
        done_count++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Job sequencing
  ////////////////////////////////////////////////////////////

  task automatic check_idle();
    check_value("o_done", 32'(o_done), 32'd0);
    check_value("o_c_valid", 32'(o_c_valid), 32'd0);
    check_value("o_a_rd_en", 32'(o_a_rd_en), 32'd0);
    check_value("o_b_rd_en", 32'(o_b_rd_en), 32'd0);
  endtask

  task automatic load_job(input int kind);
    logic [AWIDTH-1:0] base_a;
    logic [AWIDTH-1:0] base_b;
    logic [AWIDTH-1:0] base_c;
    logic [AWIDTH-1:0] addr;
    @(negedge clk);
    for (int i = 0; i < MAT_SIZE; i++) begin
      for (int k = 0; k < MAT_SIZE; k++) begin
        if (kind == JOB_IDENTITY) begin
          mat_a[i][k] = (i == k) ? 8'sd1 : 8'sd0;
          mat_b[i][k] = DWIDTH'(random_bits(DWIDTH));
        end else if (kind == JOB_SATURATE) begin
          // Only the two extremes, so every product overflows
          mat_a[i][k] = ((i + k) % 2 == 0) ? 8'sh80 : 8'sh7F;
          mat_b[i][k] = ((i + 2 * k) % 3 == 0) ? 8'sh80 : 8'sh7F;
        end else begin
          mat_a[i][k] = DWIDTH'(random_bits(DWIDTH));
          mat_b[i][k] = DWIDTH'(random_bits(DWIDTH));
        end
      end
    end
    base_a = AWIDTH'(random_bits(AWIDTH));
    base_b = AWIDTH'(random_bits(AWIDTH));
    base_c = AWIDTH'(random_bits(AWIDTH));
    // A words hold columns, B words hold rows
    for (int k = 0; k < MAT_SIZE; k++) begin
      for (int i = 0; i < MAT_SIZE; i++) begin
        addr = stride_addr(base_a, k);
        mem_a[addr][i*DWIDTH +: DWIDTH] = mat_a[i][k];
        addr = stride_addr(base_b, k);
        mem_b[addr][i*DWIDTH +: DWIDTH] = mat_b[k][i];
      end
    end
    for (int i = 0; i < MAT_SIZE; i++) begin
      for (int j = 0; j < MAT_SIZE; j++) begin
        exp_c[i][j] = (kind == JOB_IDENTITY) ? mat_b[i][j] : ref_element(i, j);
      end
    end
    i_base_a <= base_a;
    i_base_b <= base_b;
    i_base_c <= base_c;
    beat_count = 0;
    done_count = 0;
    a_fetch_count = 0;
    b_fetch_count = 0;
  endtask

  task automatic run_job();
    int edges;
    edges = 0;
    i_start <= 1'b1;
    do begin
      @(negedge clk);
      edges++;
    end while (!o_done);
    check_value("o_done cycle", 32'(edges), 32'(DONE_EDGE));
    @(negedge clk);
    check_value("o_done", 32'(o_done), 32'd0);
    i_start <= 1'b0;
    repeat (2) @(negedge clk);
    check_value("done pulses", 32'(done_count), 32'd1);
    check_value("o_c_valid beats", 32'(beat_count), 32'(MAT_SIZE));
    check_value("o_a_rd_en cycles", 32'(a_fetch_count), 32'(MAT_SIZE));
    check_value("o_b_rd_en cycles", 32'(b_fetch_count), 32'(MAT_SIZE));
    check_idle();
  endtask

  task automatic abort_job();
    load_job(JOB_RANDOM);
    i_start <= 1'b1;
    // Drop start while products are still flowing through the array
    repeat (MAT_SIZE + 4) @(negedge clk);
    i_start <= 1'b0;
    @(negedge clk);
    repeat (MAT_SIZE) begin
      check_idle();
      @(negedge clk);
    end
    check_value("o_c_valid beats", 32'(beat_count), 32'd0);
    check_value("done pulses", 32'(done_count), 32'd0);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("Verification failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    reset = 1'b1;
    i_start = 1'b0;
    i_base_a = '0;
    i_base_b = '0;
    i_base_c = '0;
    i_a_data = '0;
    i_b_data = '0;
    a_en_pipe = '0;
    b_en_pipe = '0;
    beat_count = 0;
    done_count = 0;
    a_fetch_count = 0;
    b_fetch_count = 0;
    lfsr_state = 16'(SEED);
    for (int a = 0; a < (1 << AWIDTH); a++) begin
      mem_a[a] = fill_word(AWIDTH'(a), 1'b0);
      mem_b[a] = fill_word(AWIDTH'(a), 1'b1);
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_idle();

    load_job(JOB_IDENTITY);
    run_job();
    repeat (3) begin
      load_job(JOB_RANDOM);
      run_job();
    end
    load_job(JOB_SATURATE);
    run_job();
    abort_job();
    // A fresh job after the abort must start from clean state
    load_job(JOB_RANDOM);
    run_job();

    $display("Verification passed");
    $finish;
  end

endmodule

// ==== verilog/drain_sequencer.sv ====
module drain_sequencer #(
  parameter int MEM_LAT = matmul_pkg::MEM_LATENCY
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               i_start,
  input  logic [matmul_pkg::AWIDTH-1:0]      i_base_c,
  input  logic [matmul_pkg::ACC_WIDTH-1:0]   i_acc_flat,
  output logic [matmul_pkg::CYCLE_WIDTH-1:0] o_cycle,
  output logic                               o_clear,
  output logic [matmul_pkg::AWIDTH-1:0]      o_c_addr,
  output logic [matmul_pkg::ROW_WIDTH-1:0]   o_c_data,
  output logic                               o_c_valid,
  output logic                               o_done
);

  import matmul_pkg::*;

  // Last operand pair reaches PE (N-1,N-1) after 2(N-1) hops, then the MAC pipe
  localparam int CAPTURE_CYCLE = MAT_SIZE + 2 * (MAT_SIZE - 1) + MEM_LAT + MAC_STAGES;
  localparam logic [LOG2_MAT_SIZE-1:0] LAST_COL = LOG2_MAT_SIZE'(MAT_SIZE - 1);

  logic                     running;
  logic                     capturing;
  logic                     capture_now;
  logic [LOG2_MAT_SIZE-1:0] col_sel;
  logic [AWIDTH-1:0]        col_off;
  logic [ROW_WIDTH-1:0]     col_word;

  ////////////////////////////////////////////////////////////
  // Cycle counter and done pulse
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      running <= 1'b0;
      o_cycle <= '0;
      o_done  <= 1'b0;
    end else begin
      running <= 1'b1;
      // Saturates so a long held start never replays the job
      if (running && (o_cycle != '1)) begin
        o_cycle <= o_cycle + 1'b1;
      end
      o_done <= running && (o_cycle == CYCLE_WIDTH'(DONE_CYCLE));
    end
  end

  // Array is held clear whenever no job is running
  assign o_clear = reset || !i_start;

  ////////////////////////////////////////////////////////////
  // Result column capture
  ////////////////////////////////////////////////////////////

  assign capture_now = capturing || (o_cycle == CYCLE_WIDTH'(CAPTURE_CYCLE));

  // Column j gathers lane i from accumulator (i,j)
  always_comb begin
    for (int r = 0; r < MAT_SIZE; r++) begin
      col_word[r*DWIDTH +: DWIDTH] = i_acc_flat[(r*MAT_SIZE + col_sel)*DWIDTH +: DWIDTH];
    end
  end

  assign col_off = AWIDTH'(col_sel) << LOG2_MAT_SIZE;

  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      capturing <= 1'b0;
      col_sel   <= '0;
      o_c_valid <= 1'b0;
    end else if (capture_now) begin
      capturing <= (col_sel != LAST_COL);
      col_sel   <= col_sel + 1'b1;
      o_c_valid <= 1'b1;
    end else begin
      o_c_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (capture_now) begin
      o_c_data <= col_word;
      o_c_addr <= i_base_c + col_off;
    end
  end

  // Last column must be out before done, which fails if MEM_LAT moves capture too late
  assert property (@(posedge clk) disable iff (reset) !(o_c_valid && o_done));

endmodule

// ==== verilog/matmul_pkg.sv ====
package matmul_pkg;

  ////////////////////////////////////////////////////////////
  // Data and array geometry
  ////////////////////////////////////////////////////////////

  // One matrix element, signed two's complement
  localparam int DWIDTH = 8;

  // Array is MAT_SIZE x MAT_SIZE processing elements
  localparam int MAT_SIZE = 4;
  localparam int LOG2_MAT_SIZE = 2;

  // One memory word carries a full column or row
  localparam int ROW_WIDTH = MAT_SIZE * DWIDTH;

  // All sixteen accumulators side by side, row major
  localparam int ACC_WIDTH = MAT_SIZE * MAT_SIZE * DWIDTH;

  ////////////////////////////////////////////////////////////
  // Memory side
  ////////////////////////////////////////////////////////////

  // Word address width of the A, B and C ports
  localparam int AWIDTH = 10;

  // Address in to data out, in clock cycles
  localparam int MEM_LATENCY = 2;

  ////////////////////////////////////////////////////////////
  // Job timing
  ////////////////////////////////////////////////////////////

  // Operands in to accumulator updated inside one PE
  localparam int MAC_STAGES = 3;

  // Shared time base width; the counter saturates at all ones
  localparam int CYCLE_WIDTH = 8;

  // Count at which the done pulse is issued
  localparam int DONE_CYCLE = 4 * MAT_SIZE + 3;

endpackage

// ==== verilog/matmul_tile.sv ====
module matmul_tile #(
  parameter int MEM_LAT = matmul_pkg::MEM_LATENCY
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             i_start,
  input  logic [matmul_pkg::AWIDTH-1:0]    i_base_a,
  input  logic [matmul_pkg::AWIDTH-1:0]    i_base_b,
  input  logic [matmul_pkg::AWIDTH-1:0]    i_base_c,
  input  logic [matmul_pkg::ROW_WIDTH-1:0] i_a_data,
  input  logic [matmul_pkg::ROW_WIDTH-1:0] i_b_data,
  output logic [matmul_pkg::AWIDTH-1:0]    o_a_addr,
  output logic [matmul_pkg::AWIDTH-1:0]    o_b_addr,
  output logic                             o_a_rd_en,
  output logic                             o_b_rd_en,
  output logic [matmul_pkg::AWIDTH-1:0]    o_c_addr,
  output logic [matmul_pkg::ROW_WIDTH-1:0] o_c_data,
  output logic                             o_c_valid,
  output logic                             o_done
);

  import matmul_pkg::*;

  logic [CYCLE_WIDTH-1:0] cycle;
  logic                   array_clear;
  logic [ROW_WIDTH-1:0]   a_lanes;
  logic [ROW_WIDTH-1:0]   b_lanes;
  logic [ACC_WIDTH-1:0]   acc_flat;

  ////////////////////////////////////////////////////////////
  // Operand feeders, A columns and B rows
  ////////////////////////////////////////////////////////////

  operand_feeder #(.MEM_LAT(MEM_LAT)) u_feed_a (
    .clk        (clk),
    .reset      (reset),
    .i_start    (i_start),
    .i_cycle    (cycle),
    .i_base     (i_base_a),
    .i_mem_data (i_a_data),
    .o_addr     (o_a_addr),
    .o_rd_en    (o_a_rd_en),
    .o_lanes    (a_lanes)
  );

  operand_feeder #(.MEM_LAT(MEM_LAT)) u_feed_b (
    .clk        (clk),
    .reset      (reset),
    .i_start    (i_start),
    .i_cycle    (cycle),
    .i_base     (i_base_b),
    .i_mem_data (i_b_data),
    .o_addr     (o_b_addr),
    .o_rd_en    (o_b_rd_en),
    .o_lanes    (b_lanes)
  );

  ////////////////////////////////////////////////////////////
  // Array and result drain
  ////////////////////////////////////////////////////////////

  systolic_array u_array (
    .clk        (clk),
    .i_clear    (array_clear),
    .i_a_lanes  (a_lanes),
    .i_b_lanes  (b_lanes),
    .o_acc_flat (acc_flat)
  );

  drain_sequencer #(.MEM_LAT(MEM_LAT)) u_drain (
    .clk        (clk),
    .reset      (reset),
    .i_start    (i_start),
    .i_base_c   (i_base_c),
    .i_acc_flat (acc_flat),
    .o_cycle    (cycle),
    .o_clear    (array_clear),
    .o_c_addr   (o_c_addr),
    .o_c_data   (o_c_data),
    .o_c_valid  (o_c_valid),
    .o_done     (o_done)
  );

endmodule

// ==== verilog/operand_feeder.sv ====
module operand_feeder #(
  parameter int MEM_LAT = matmul_pkg::MEM_LATENCY
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               i_start,
  input  logic [matmul_pkg::CYCLE_WIDTH-1:0] i_cycle,
  input  logic [matmul_pkg::AWIDTH-1:0]      i_base,
  input  logic [matmul_pkg::ROW_WIDTH-1:0]   i_mem_data,
  output logic [matmul_pkg::AWIDTH-1:0]      o_addr,
  output logic                               o_rd_en,
  output logic [matmul_pkg::ROW_WIDTH-1:0]   o_lanes
);

  import matmul_pkg::*;

  logic                 run_q;
  logic                 in_window;
  logic [AWIDTH-1:0]    stride_off;
  logic [MEM_LAT-1:0]   lat_pipe;
  logic                 data_valid;
  logic [ROW_WIDTH-1:0] masked;

  ////////////////////////////////////////////////////////////
  // Fetch window and address stride
  ////////////////////////////////////////////////////////////

  // Count sits at 0 for one extra cycle while the job starts up
  always_ff @(posedge clk) begin
    if (reset) begin
      run_q <= 1'b0;
    end else begin
      run_q <= i_start;
    end
  end

  assign in_window = (i_cycle < CYCLE_WIDTH'(MAT_SIZE));
  assign o_rd_en = run_q && in_window;

  // Word k lives at base + k*N
  assign stride_off = AWIDTH'(i_cycle[LOG2_MAT_SIZE-1:0]) << LOG2_MAT_SIZE;
  assign o_addr = i_base + stride_off;

  ////////////////////////////////////////////////////////////
  // Memory latency tracking and valid masking
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      lat_pipe <= '0;
    end else begin
      lat_pipe[0] <= o_rd_en;
      for (int s = 1; s < MEM_LAT; s++) begin
        lat_pipe[s] <= lat_pipe[s-1];
      end
    end
  end

  assign data_valid = lat_pipe[MEM_LAT-1];

  // Zero lanes keep the accumulators untouched outside the window
  assign masked = i_mem_data & {ROW_WIDTH{data_valid}};

  ////////////////////////////////////////////////////////////
  // Triangular skew, lane i delayed by i cycles
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < MAT_SIZE; i++) begin : g_lane
    if (i == 0) begin : g_direct
      assign o_lanes[DWIDTH-1:0] = masked[DWIDTH-1:0];
    end else begin : g_delay
      logic [DWIDTH-1:0] dly [i];

      // Flushed on restart so an aborted job leaves nothing behind
      always_ff @(posedge clk) begin
        if (reset || !i_start) begin
          for (int s = 0; s < i; s++) begin
            dly[s] <= '0;
          end
        end else begin
          dly[0] <= masked[i*DWIDTH +: DWIDTH];
          for (int s = 1; s < i; s++) begin
            dly[s] <= dly[s-1];
          end
        end
      end

      assign o_lanes[i*DWIDTH +: DWIDTH] = dly[i-1];
    end
  end

  // A fetch burst is over by count N, N cycles after it began
  assert property (@(posedge clk) disable iff (reset || !i_start)
    $rose(o_rd_en) |-> ##MAT_SIZE !o_rd_en);

endmodule

// ==== verilog/sat_mac_pe.sv ====
module sat_mac_pe (
  input  logic                          clk,
  input  logic                          i_clear,
  input  logic [matmul_pkg::DWIDTH-1:0] i_a,
  input  logic [matmul_pkg::DWIDTH-1:0] i_b,
  output logic [matmul_pkg::DWIDTH-1:0] o_a,
  output logic [matmul_pkg::DWIDTH-1:0] o_b,
  output logic [matmul_pkg::DWIDTH-1:0] o_acc
);

  import matmul_pkg::*;

  localparam int PROD_W = 2 * DWIDTH;
  localparam logic signed [PROD_W-1:0] PROD_MAX = 2 ** (DWIDTH - 1) - 1;
  localparam logic signed [PROD_W-1:0] PROD_MIN = -(2 ** (DWIDTH - 1));

  logic signed [DWIDTH-1:0] a_q;
  logic signed [DWIDTH-1:0] b_q;
  logic signed [PROD_W-1:0] mult_full;
  logic signed [PROD_W-1:0] prod_q;
  logic signed [PROD_W-1:0] sat_ext;
  logic                     pos_ovf;
  logic                     neg_ovf;
  logic [DWIDTH-1:0]        sat_prod;
  logic [DWIDTH-1:0]        acc_q;

  ////////////////////////////////////////////////////////////
  // Operand, product and accumulator stages
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (i_clear) begin
      a_q    <= '0;
      b_q    <= '0;
      prod_q <= '0;
      acc_q  <= '0;
    end else begin
      a_q    <= i_a;
      b_q    <= i_b;
      prod_q <= mult_full;
      // Accumulator wraps on purpose
      acc_q  <= acc_q + sat_prod;
    end
  end

  // Full precision signed product
  assign mult_full = a_q * b_q;

  ////////////////////////////////////////////////////////////
  // Saturate the registered product to DWIDTH bits
  ////////////////////////////////////////////////////////////

  // Overflow when the upper bits differ from the sign
  assign pos_ovf = !prod_q[PROD_W-1] && (|prod_q[PROD_W-2:DWIDTH-1]);
  assign neg_ovf = prod_q[PROD_W-1] && !(&prod_q[PROD_W-2:DWIDTH-1]);

  assign sat_prod = pos_ovf ? {1'b0, {(DWIDTH-1){1'b1}}} :
                    neg_ovf ? {1'b1, {(DWIDTH-1){1'b0}}} :
                    prod_q[DWIDTH-1:0];

  assign sat_ext = {{DWIDTH{sat_prod[DWIDTH-1]}}, sat_prod};

  // Operands move on to the neighbours one cycle later
  assign o_a   = a_q;
  assign o_b   = b_q;
  assign o_acc = acc_q;

  // Saturated value is the product of the previous cycle clamped to the signed range
  assert property (@(posedge clk) !$past(i_clear) |->
    sat_ext == (($past(mult_full) > PROD_MAX) ? PROD_MAX :
                ($past(mult_full) < PROD_MIN) ? PROD_MIN : $past(mult_full)));

endmodule

// ==== verilog/systolic_array.sv ====
module systolic_array (
  input  logic                             clk,
  input  logic                             i_clear,
  input  logic [matmul_pkg::ROW_WIDTH-1:0] i_a_lanes,
  input  logic [matmul_pkg::ROW_WIDTH-1:0] i_b_lanes,
  output logic [matmul_pkg::ACC_WIDTH-1:0] o_acc_flat
);

  import matmul_pkg::*;

  // A runs left to right, one extra column for the far edge
  logic [DWIDTH-1:0] a_h [MAT_SIZE][MAT_SIZE+1];
  // B runs top to bottom, one extra row for the far edge
  logic [DWIDTH-1:0] b_v [MAT_SIZE+1][MAT_SIZE];

  ////////////////////////////////////////////////////////////
  // Edge feeds
  ////////////////////////////////////////////////////////////

  for (genvar r = 0; r < MAT_SIZE; r++) begin : g_a_edge
    assign a_h[r][0] = i_a_lanes[r*DWIDTH +: DWIDTH];
  end

  for (genvar c = 0; c < MAT_SIZE; c++) begin : g_b_edge
    assign b_v[0][c] = i_b_lanes[c*DWIDTH +: DWIDTH];
  end

  ////////////////////////////////////////////////////////////
  // PE grid
  ////////////////////////////////////////////////////////////

  for (genvar r = 0; r < MAT_SIZE; r++) begin : g_row
    for (genvar c = 0; c < MAT_SIZE; c++) begin : g_col
      // Accumulator (r,c) lands at row major slot r*N+c
      sat_mac_pe u_pe (
        .clk     (clk),
        .i_clear (i_clear),
        .i_a     (a_h[r][c]),
        .i_b     (b_v[r][c]),
        .o_a     (a_h[r][c+1]),
        .o_b     (b_v[r+1][c]),
        .o_acc   (o_acc_flat[(r*MAT_SIZE+c)*DWIDTH +: DWIDTH])
      );
    end
  end

endmodule
